// File: nebula_pkg.sv
/* Nebula fabric shared definitions */
package nebula_pkg;

    typedef logic [31:0] wb_addr_t;    // Byte address
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;     // One bit per byte lane
    typedef logic [3:0]  team_idx_t;   // 0 means no team

    // Address map, one 1 MiB window per block
    localparam wb_addr_t WIN_MASK    = 32'hFFF0_0000;
    localparam wb_addr_t SRAM_BASE   = 32'h3000_0000;
    localparam wb_addr_t GPIO_BASE   = 32'h3010_0000;
    localparam wb_addr_t LA_BASE     = 32'h3020_0000;
    localparam wb_addr_t TEAM_BASE   = 32'h3030_0000;
    localparam wb_addr_t TEAM_STRIDE = 32'h0001_0000;  // 64 KiB per team

    // Decoder port order
    localparam int P_SRAM  = 0;
    localparam int P_GPIO  = 1;
    localparam int P_LA    = 2;
    localparam int P_TEAM0 = 3;    // Team t on port P_TEAM0 + t - 1

    localparam wb_data_t ERR_WORD = 32'hDEAD_BEEF;  // Unmapped read data

endpackage

// File: wb_arbiter.sv
/* Two-manager Wishbone arbiter */
`timescale 1ns/1ps

module wb_arbiter (
    input  logic                 wb_clk_i,
    input  logic                 rst_i,
    // External manager
    input  logic                 m0_cyc_i, m0_stb_i, m0_we_i,
    input  nebula_pkg::wb_addr_t m0_adr_i,
    input  nebula_pkg::wb_data_t m0_dat_i,
    input  nebula_pkg::wb_sel_t  m0_sel_i,
    output logic                 m0_ack_o,
    output nebula_pkg::wb_data_t m0_dat_o,
    // Team 1 manager
    input  logic                 m1_cyc_i, m1_stb_i, m1_we_i,
    input  nebula_pkg::wb_addr_t m1_adr_i,
    input  nebula_pkg::wb_data_t m1_dat_i,
    input  nebula_pkg::wb_sel_t  m1_sel_i,
    output logic                 m1_ack_o,
    output nebula_pkg::wb_data_t m1_dat_o,
    // Shared bus toward the decoder
    output logic                 s_cyc_o, s_stb_o, s_we_o,
    output nebula_pkg::wb_addr_t s_adr_o,
    output nebula_pkg::wb_data_t s_dat_o,
    output nebula_pkg::wb_sel_t  s_sel_o,
    input  logic                 s_ack_i,
    input  nebula_pkg::wb_data_t s_dat_i
);

    typedef enum logic [1:0] {ARB_IDLE, ARB_GNT0, ARB_GNT1} arb_state_t;

    arb_state_t state_q;
    arb_state_t state_d;
    logic       gnt0;
    logic       gnt1;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE:
                if (m0_cyc_i)
                    state_d = ARB_GNT0;    // External port wins a tie
                else if (m1_cyc_i)
                    state_d = ARB_GNT1;
            ARB_GNT0:
                if (!m0_cyc_i)
                    state_d = m1_cyc_i ? ARB_GNT1 : ARB_IDLE;  // Hand over to a waiter
            ARB_GNT1:
                if (!m1_cyc_i)
                    state_d = m0_cyc_i ? ARB_GNT0 : ARB_IDLE;
            default: state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (rst_i)
            state_q <= ARB_IDLE;
        else
            state_q <= state_d;
    end

    assign gnt0 = (state_q == ARB_GNT0);
    assign gnt1 = (state_q == ARB_GNT1);

    // Only the owner reaches the slaves, the other manager stalls
    assign s_cyc_o = (gnt0 & m0_cyc_i) | (gnt1 & m1_cyc_i);
    assign s_stb_o = (gnt0 & m0_stb_i) | (gnt1 & m1_stb_i);
    assign s_we_o  = gnt1 ? m1_we_i  : m0_we_i;
    assign s_adr_o = gnt1 ? m1_adr_i : m0_adr_i;
    assign s_dat_o = gnt1 ? m1_dat_i : m0_dat_i;
    assign s_sel_o = gnt1 ? m1_sel_i : m0_sel_i;

    assign m0_ack_o = gnt0 & s_ack_i;
    assign m1_ack_o = gnt1 & s_ack_i;
    assign m0_dat_o = s_dat_i;    // Qualified by ack
    assign m1_dat_o = s_dat_i;

    // Ack only returns to a manager whose cycle is still open
    a_ack_in_cycle: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        !(m0_ack_o && !m0_cyc_i) && !(m1_ack_o && !m1_cyc_i));

endmodule

// File: wb_decoder.sv
/* Wishbone address decoder */
`timescale 1ns/1ps

module wb_decoder #(
    parameter int NUM_TEAMS = 2
) (
    input  logic                                 wb_clk_i,
    input  logic                                 rst_i,
    // Granted manager
    input  logic                                 m_cyc_i, m_stb_i, m_we_i,
    input  nebula_pkg::wb_addr_t                 m_adr_i,
    input  nebula_pkg::wb_data_t                 m_dat_i,
    input  nebula_pkg::wb_sel_t                  m_sel_i,
    output logic                                 m_ack_o,
    output nebula_pkg::wb_data_t                 m_dat_o,
    // Slave ports
    output logic [NUM_TEAMS+2:0]                 p_cyc_o, p_stb_o,
    output logic                                 p_we_o,
    output nebula_pkg::wb_addr_t                 p_adr_o,
    output nebula_pkg::wb_data_t                 p_dat_o,
    output nebula_pkg::wb_sel_t                  p_sel_o,
    input  logic [NUM_TEAMS+2:0]                 p_ack_i,
    input  nebula_pkg::wb_data_t [NUM_TEAMS+2:0] p_dat_i
);
    import nebula_pkg::*;

    localparam int NP = NUM_TEAMS + 3;

    wb_addr_t      win;
    team_idx_t     team;
    logic [NP-1:0] hit;
    logic          unmapped;
    logic          err_ack_q;

    assign win  = m_adr_i & WIN_MASK;
    assign team = team_idx_t'((m_adr_i & ~WIN_MASK) / TEAM_STRIDE);  // adr[19:16]

    // Each window compared on its own
    always_comb begin
        hit = '0;
        hit[P_SRAM] = (win == SRAM_BASE);
        hit[P_GPIO] = (win == GPIO_BASE);
        hit[P_LA]   = (win == LA_BASE);
        for (int t = 1; t <= NUM_TEAMS; t++)
            hit[P_TEAM0 + t - 1] = (win == TEAM_BASE) && (int'(team) == t);
    end

    assign unmapped = (hit == '0);

    assign p_cyc_o = hit & {NP{m_cyc_i}};
    assign p_stb_o = hit & {NP{m_cyc_i & m_stb_i}};
    assign p_we_o  = m_we_i;
    assign p_adr_o = m_adr_i;
    assign p_dat_o = m_dat_i;
    assign p_sel_o = m_sel_i;

    // Error slave for holes in the map
    always_ff @(posedge wb_clk_i) begin
        if (rst_i)
            err_ack_q <= 1'b0;
        else
            err_ack_q <= m_cyc_i & m_stb_i & unmapped & ~err_ack_q;
    end

    assign m_ack_o = (|(p_ack_i & hit)) | err_ack_q;

    always_comb begin
        m_dat_o = ERR_WORD;
        for (int i = 0; i < NP; i++)
            if (hit[i])
                m_dat_o = p_dat_i[i];
    end

    a_cyc_onehot: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        $onehot0(p_cyc_o));

endmodule

// File: wb_sram.sv
/* Behavioral word SRAM */
`timescale 1ns/1ps

module wb_sram #(
    parameter int SRAM_WORDS = 256
) (
    input  logic                 wb_clk_i,
    input  logic                 rst_i,
    input  logic                 wbs_cyc_i, wbs_stb_i, wbs_we_i,
    input  nebula_pkg::wb_addr_t wbs_adr_i,
    input  nebula_pkg::wb_data_t wbs_dat_i,
    input  nebula_pkg::wb_sel_t  wbs_sel_i,
    output logic                 wbs_ack_o,
    output nebula_pkg::wb_data_t wbs_dat_o
);
    import nebula_pkg::*;

    localparam int AW = $clog2(SRAM_WORDS);

    wb_data_t      mem [SRAM_WORDS];
    logic [AW-1:0] idx;
    logic          acc;

    assign idx = AW'(wbs_adr_i[9:2] % SRAM_WORDS);   // Word address wraps
    assign acc = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i)
            wbs_ack_o <= 1'b0;
        else
            wbs_ack_o <= acc;
    end

    always_ff @(posedge wb_clk_i) begin
        if (acc) begin
            wbs_dat_o <= mem[idx];   // Old word on a write
            if (wbs_we_i)
                for (int b = 0; b < 4; b++)
                    if (wbs_sel_i[b])
                        mem[idx][8*b +: 8] <= wbs_dat_i[8*b +: 8];
        end
    end

endmodule

// File: gpio_mux.sv
/* GPIO pad team selector */
`timescale 1ns/1ps

module gpio_mux #(
    parameter int NUM_TEAMS = 2
) (
    input  logic                    wb_clk_i,
    input  logic                    rst_i,
    input  logic                    wbs_cyc_i, wbs_stb_i, wbs_we_i,
    input  nebula_pkg::wb_addr_t    wbs_adr_i,
    input  nebula_pkg::wb_data_t    wbs_dat_i,
    input  nebula_pkg::wb_sel_t     wbs_sel_i,
    output logic                    wbs_ack_o,
    output nebula_pkg::wb_data_t    wbs_dat_o,
    input  logic [NUM_TEAMS*38-1:0] designs_gpio_out_i,
    input  logic [NUM_TEAMS*38-1:0] designs_gpio_oeb_i,
    output logic [37:0]             io_out_o,
    output logic [37:0]             io_oeb_o
);
    import nebula_pkg::*;

    team_idx_t  pin_sel_q [38];
    logic [5:0] pin;
    logic       pin_ok;
    logic       acc;

    assign pin    = wbs_adr_i[7:2];   // One word per pin
    assign pin_ok = (pin < 6'd38);
    assign acc    = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            wbs_ack_o <= 1'b0;
            for (int p = 0; p < 38; p++)
                pin_sel_q[p] <= '0;
        end else begin
            wbs_ack_o <= acc;
            if (acc && wbs_we_i && wbs_sel_i[0] && pin_ok)
                pin_sel_q[pin] <= team_idx_t'(wbs_dat_i[3:0]);
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (acc)
            wbs_dat_o <= pin_ok ? wb_data_t'(pin_sel_q[pin]) : '0;
    end

    // Unselected or out-of-range pads stay as inputs driving 0
    always_comb begin
        for (int p = 0; p < 38; p++) begin
            io_out_o[p] = 1'b0;
            io_oeb_o[p] = 1'b1;
            if (pin_sel_q[p] != '0 && int'(pin_sel_q[p]) <= NUM_TEAMS) begin
                io_out_o[p] = designs_gpio_out_i[(int'(pin_sel_q[p]) - 1) * 38 + p];
                io_oeb_o[p] = designs_gpio_oeb_i[(int'(pin_sel_q[p]) - 1) * 38 + p];
            end
        end
    end

endmodule

// File: la_mux.sv
/* Logic analyzer lane selector */
`timescale 1ns/1ps

module la_mux #(
    parameter int NUM_TEAMS = 2
) (
    input  logic                     wb_clk_i,
    input  logic                     rst_i,
    input  logic                     wbs_cyc_i, wbs_stb_i, wbs_we_i,
    input  nebula_pkg::wb_addr_t     wbs_adr_i,
    input  nebula_pkg::wb_data_t     wbs_dat_i,
    input  nebula_pkg::wb_sel_t      wbs_sel_i,
    output logic                     wbs_ack_o,
    output nebula_pkg::wb_data_t     wbs_dat_o,
    input  logic [NUM_TEAMS*128-1:0] designs_la_out_i,
    output logic [127:0]             la_data_out_o
);
    import nebula_pkg::*;

    team_idx_t  lane_sel_q [4];
    logic [1:0] lane;
    logic       acc;

    assign lane = wbs_adr_i[3:2];
    assign acc  = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            wbs_ack_o <= 1'b0;
            for (int k = 0; k < 4; k++)
                lane_sel_q[k] <= '0;
        end else begin
            wbs_ack_o <= acc;
            if (acc && wbs_we_i && wbs_sel_i[0])
                lane_sel_q[lane] <= team_idx_t'(wbs_dat_i[3:0]);
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (acc)
            wbs_dat_o <= wb_data_t'(lane_sel_q[lane]);
    end

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            la_data_out_o[32*k +: 32] = '0;    // Lane idle without a valid team
            if (lane_sel_q[k] != '0 && int'(lane_sel_q[k]) <= NUM_TEAMS)
                la_data_out_o[32*k +: 32] =
                    designs_la_out_i[(int'(lane_sel_q[k]) - 1) * 128 + 32*k +: 32];
        end
    end

endmodule

// File: team_sample.sv
/* Sample team project */
`timescale 1ns/1ps

module team_sample (
    input  logic                 wb_clk_i,
    input  logic                 rst_i,
    // Slave port
    input  logic                 wbs_cyc_i, wbs_stb_i, wbs_we_i,
    input  nebula_pkg::wb_addr_t wbs_adr_i,
    input  nebula_pkg::wb_data_t wbs_dat_i,
    input  nebula_pkg::wb_sel_t  wbs_sel_i,
    output logic                 wbs_ack_o,
    output nebula_pkg::wb_data_t wbs_dat_o,
    // Copy manager port
    output logic                 mst_cyc_o, mst_stb_o, mst_we_o,
    output nebula_pkg::wb_addr_t mst_adr_o,
    output nebula_pkg::wb_data_t mst_dat_o,
    output nebula_pkg::wb_sel_t  mst_sel_o,
    input  logic                 mst_ack_i,
    input  nebula_pkg::wb_data_t mst_dat_i,
    // Pads and logic analyzer
    input  logic [37:0]          gpio_in_i,
    output logic [37:0]          gpio_out_o,
    output logic [37:0]          gpio_oeb_o,
    input  logic [127:0]         la_in_i,
    output logic [127:0]         la_out_o
);
    import nebula_pkg::*;

    typedef enum logic {CP_IDLE, CP_WAIT_ACK} copy_state_t;

    copy_state_t state_q;
    wb_data_t    scratch_q;
    wb_data_t    copy_dat_q;
    logic [7:0]  copy_addr_q;
    logic [7:0]  copy_word_q;
    logic [15:0] reply_q;
    logic [1:0]  reg_idx;
    logic        acc;
    logic        busy;
    logic        start;

    assign reg_idx = wbs_adr_i[3:2];
    assign acc     = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;
    assign busy    = (state_q == CP_WAIT_ACK);
    assign start   = acc & wbs_we_i & (reg_idx == 2'd1) & wbs_sel_i[0] & wbs_dat_i[0] & ~busy;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            wbs_ack_o   <= 1'b0;
            scratch_q   <= '0;
            copy_addr_q <= '0;
        end else begin
            wbs_ack_o <= acc;
            if (acc && wbs_we_i && reg_idx == 2'd0)
                for (int b = 0; b < 4; b++)
                    if (wbs_sel_i[b])
                        scratch_q[8*b +: 8] <= wbs_dat_i[8*b +: 8];
            if (acc && wbs_we_i && reg_idx == 2'd2 && wbs_sel_i[0])
                copy_addr_q <= wbs_dat_i[7:0];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (acc) begin
            case (reg_idx)
                2'd0: wbs_dat_o <= scratch_q;
                2'd1: wbs_dat_o <= {reply_q, la_in_i[7:0], 6'b0, busy, 1'b0};
                2'd2: wbs_dat_o <= {24'b0, copy_addr_q};
                default: wbs_dat_o <= gpio_in_i[31:0];
            endcase
        end
    end

    // Copy manager, one SRAM write per start
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            state_q <= CP_IDLE;
            reply_q <= '0;
        end else begin
            case (state_q)
                CP_IDLE:
                    if (start)
                        state_q <= CP_WAIT_ACK;
                CP_WAIT_ACK:
                    if (mst_ack_i) begin
                        state_q <= CP_IDLE;
                        reply_q <= mst_dat_i[15:0];  // Previous SRAM word
                    end
                default: state_q <= CP_IDLE;
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (start) begin
            copy_dat_q  <= scratch_q;
            copy_word_q <= copy_addr_q;
        end
    end

    assign mst_cyc_o = busy;
    assign mst_stb_o = busy;
    assign mst_we_o  = 1'b1;
    assign mst_adr_o = SRAM_BASE | {22'b0, copy_word_q, 2'b00};
    assign mst_dat_o = copy_dat_q;
    assign mst_sel_o = 4'hF;

    assign gpio_out_o = {30'b0, scratch_q[7:0]};
    assign gpio_oeb_o = {{30{1'b1}}, 8'h00};   // Only pins 7:0 driven
    assign la_out_o   = {4{scratch_q}};

    // Ack from the fabric only arrives while a copy is pending
    a_ack_while_busy: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        mst_ack_i |-> busy);

endmodule

// File: nebula_top.sv
/* Nebula user-area fabric */
`timescale 1ns/1ps

module nebula_top #(
    parameter int NUM_TEAMS  = 2,
    parameter int SRAM_WORDS = 256
) (
    input  logic                 wb_clk_i,
    input  logic                 rst_i,
    input  logic                 wbs_stb_i, wbs_cyc_i, wbs_we_i,
    input  nebula_pkg::wb_sel_t  wbs_sel_i,
    input  nebula_pkg::wb_data_t wbs_dat_i,
    input  nebula_pkg::wb_addr_t wbs_adr_i,
    output logic                 wbs_ack_o,
    output nebula_pkg::wb_data_t wbs_dat_o,
    input  logic [127:0]         la_data_in_i,
    output logic [127:0]         la_data_out_o,
    input  logic [37:0]          io_in_i,
    output logic [37:0]          io_out_o,
    output logic [37:0]          io_oeb_o,
    output logic [2:0]           irq_o
);
    import nebula_pkg::*;

    localparam int NP = NUM_TEAMS + 3;

    // Team manager ports, only team 1 reaches the arbiter
    logic     [NUM_TEAMS-1:0] tm_cyc, tm_stb, tm_we;
    wb_addr_t [NUM_TEAMS-1:0] tm_adr;
    wb_data_t [NUM_TEAMS-1:0] tm_dat;
    wb_sel_t  [NUM_TEAMS-1:0] tm_sel;
    logic                     m1_ack;
    wb_data_t                 m1_dat;

    // Arbiter to decoder
    logic     s_cyc, s_stb, s_we, s_ack;
    wb_addr_t s_adr;
    wb_data_t s_dat_w;
    wb_data_t s_dat_r;
    wb_sel_t  s_sel;

    // Decoder to slaves
    logic [NP-1:0]   p_cyc, p_stb, p_ack;
    logic            p_we;
    wb_addr_t        p_adr;
    wb_data_t        p_dat_w;
    wb_sel_t         p_sel;
    wb_data_t [NP-1:0] p_dat_r;

    logic [NUM_TEAMS*38-1:0]  team_gpio_out, team_gpio_oeb;
    logic [NUM_TEAMS*128-1:0] team_la_out;

    assign irq_o = 3'b0;

    wb_arbiter u_arbiter (
        .wb_clk_i(wb_clk_i), .rst_i(rst_i),
        .m0_cyc_i(wbs_cyc_i), .m0_stb_i(wbs_stb_i), .m0_we_i(wbs_we_i),
        .m0_adr_i(wbs_adr_i), .m0_dat_i(wbs_dat_i), .m0_sel_i(wbs_sel_i),
        .m0_ack_o(wbs_ack_o), .m0_dat_o(wbs_dat_o),
        .m1_cyc_i(tm_cyc[0]), .m1_stb_i(tm_stb[0]), .m1_we_i(tm_we[0]),
        .m1_adr_i(tm_adr[0]), .m1_dat_i(tm_dat[0]), .m1_sel_i(tm_sel[0]),
        .m1_ack_o(m1_ack), .m1_dat_o(m1_dat),
        .s_cyc_o(s_cyc), .s_stb_o(s_stb), .s_we_o(s_we),
        .s_adr_o(s_adr), .s_dat_o(s_dat_w), .s_sel_o(s_sel),
        .s_ack_i(s_ack), .s_dat_i(s_dat_r)
    );

    wb_decoder #(.NUM_TEAMS(NUM_TEAMS)) u_decoder (
        .wb_clk_i(wb_clk_i), .rst_i(rst_i),
        .m_cyc_i(s_cyc), .m_stb_i(s_stb), .m_we_i(s_we),
        .m_adr_i(s_adr), .m_dat_i(s_dat_w), .m_sel_i(s_sel),
        .m_ack_o(s_ack), .m_dat_o(s_dat_r),
        .p_cyc_o(p_cyc), .p_stb_o(p_stb), .p_we_o(p_we),
        .p_adr_o(p_adr), .p_dat_o(p_dat_w), .p_sel_o(p_sel),
        .p_ack_i(p_ack), .p_dat_i(p_dat_r)
    );

    wb_sram #(.SRAM_WORDS(SRAM_WORDS)) u_sram (
        .wb_clk_i(wb_clk_i), .rst_i(rst_i),
        .wbs_cyc_i(p_cyc[P_SRAM]), .wbs_stb_i(p_stb[P_SRAM]), .wbs_we_i(p_we),
        .wbs_adr_i(p_adr), .wbs_dat_i(p_dat_w), .wbs_sel_i(p_sel),
        .wbs_ack_o(p_ack[P_SRAM]), .wbs_dat_o(p_dat_r[P_SRAM])
    );

    gpio_mux #(.NUM_TEAMS(NUM_TEAMS)) u_gpio_mux (
        .wb_clk_i(wb_clk_i), .rst_i(rst_i),
        .wbs_cyc_i(p_cyc[P_GPIO]), .wbs_stb_i(p_stb[P_GPIO]), .wbs_we_i(p_we),
        .wbs_adr_i(p_adr), .wbs_dat_i(p_dat_w), .wbs_sel_i(p_sel),
        .wbs_ack_o(p_ack[P_GPIO]), .wbs_dat_o(p_dat_r[P_GPIO]),
        .designs_gpio_out_i(team_gpio_out), .designs_gpio_oeb_i(team_gpio_oeb),
        .io_out_o(io_out_o), .io_oeb_o(io_oeb_o)
    );

    la_mux #(.NUM_TEAMS(NUM_TEAMS)) u_la_mux (
        .wb_clk_i(wb_clk_i), .rst_i(rst_i),
        .wbs_cyc_i(p_cyc[P_LA]), .wbs_stb_i(p_stb[P_LA]), .wbs_we_i(p_we),
        .wbs_adr_i(p_adr), .wbs_dat_i(p_dat_w), .wbs_sel_i(p_sel),
        .wbs_ack_o(p_ack[P_LA]), .wbs_dat_o(p_dat_r[P_LA]),
        .designs_la_out_i(team_la_out), .la_data_out_o(la_data_out_o)
    );

    // Team t lives at TEAM_BASE + t * TEAM_STRIDE
    for (genvar t = 1; t <= NUM_TEAMS; t++) begin : g_team
        team_sample u_team (
            .wb_clk_i(wb_clk_i), .rst_i(rst_i),
            .wbs_cyc_i(p_cyc[P_TEAM0+t-1]), .wbs_stb_i(p_stb[P_TEAM0+t-1]),
            .wbs_we_i(p_we), .wbs_adr_i(p_adr), .wbs_dat_i(p_dat_w), .wbs_sel_i(p_sel),
            .wbs_ack_o(p_ack[P_TEAM0+t-1]), .wbs_dat_o(p_dat_r[P_TEAM0+t-1]),
            .mst_cyc_o(tm_cyc[t-1]), .mst_stb_o(tm_stb[t-1]), .mst_we_o(tm_we[t-1]),
            .mst_adr_o(tm_adr[t-1]), .mst_dat_o(tm_dat[t-1]), .mst_sel_o(tm_sel[t-1]),
            .mst_ack_i(t == 1 ? m1_ack : 1'b0),
            .mst_dat_i(t == 1 ? m1_dat : 32'h0),
            .gpio_in_i(io_in_i),
            .gpio_out_o(team_gpio_out[(t-1)*38 +: 38]),
            .gpio_oeb_o(team_gpio_oeb[(t-1)*38 +: 38]),
            .la_in_i(la_data_in_i),
            .la_out_o(team_la_out[(t-1)*128 +: 128])
        );
    end

endmodule

// File: tb_nebula.sv
/* Nebula fabric directed testbench */
`timescale 1ns/1ps

module tb_nebula;

    localparam logic [31:0] SRAM_BASE   = 32'h3000_0000;
    localparam logic [31:0] GPIO_BASE   = 32'h3010_0000;
    localparam logic [31:0] LA_BASE     = 32'h3020_0000;
    localparam logic [31:0] TEAM_BASE   = 32'h3030_0000;
    localparam logic [31:0] TEAM_STRIDE = 32'h0001_0000;
    localparam int          ACK_TIMEOUT = 50;     // Cycles per access

    logic         wb_clk_i;
    logic         rst_i;
    logic         wbs_stb_i, wbs_cyc_i, wbs_we_i;
    logic [3:0]   wbs_sel_i;
    logic [31:0]  wbs_dat_i, wbs_adr_i;
    logic         wbs_ack_o;
    logic [31:0]  wbs_dat_o;
    logic [127:0] la_data_in_i, la_data_out_o;
    logic [37:0]  io_in_i, io_out_o, io_oeb_o;
    logic [2:0]   irq_o;

    integer       seed;
    logic [31:0]  sram_model [256];   // Expected SRAM contents

    nebula_top #(.NUM_TEAMS(2), .SRAM_WORDS(256)) dut (
        .wb_clk_i(wb_clk_i), .rst_i(rst_i),
        .wbs_stb_i(wbs_stb_i), .wbs_cyc_i(wbs_cyc_i), .wbs_we_i(wbs_we_i),
        .wbs_sel_i(wbs_sel_i), .wbs_dat_i(wbs_dat_i), .wbs_adr_i(wbs_adr_i),
        .wbs_ack_o(wbs_ack_o), .wbs_dat_o(wbs_dat_o),
        .la_data_in_i(la_data_in_i), .la_data_out_o(la_data_out_o),
        .io_in_i(io_in_i), .io_out_o(io_out_o), .io_oeb_o(io_oeb_o),
        .irq_o(irq_o)
    );

    always #20 wb_clk_i = ~wb_clk_i;

    task automatic stop_with_failure;
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    function automatic logic [31:0] team_addr(input int team, input int reg_idx);
        return TEAM_BASE + team * TEAM_STRIDE + 32'(reg_idx * 4);
    endfunction

    // One external access, inputs change 2 ns after the edge
    task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                             input logic [3:0] sel, output logic [31:0] rdat);
        int cycles;
        cycles = 0;
        @(posedge wb_clk_i);
        #2;
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        wbs_we_i  = we;
        wbs_adr_i = adr;
        wbs_dat_i = wdat;
        wbs_sel_i = sel;
        @(posedge wb_clk_i);
        #1;
        while (wbs_ack_o !== 1'b1) begin
            if (cycles == ACK_TIMEOUT) begin
                $display("Timeout: no ack for the access at address %h", adr);
                stop_with_failure();
            end
            cycles++;
            @(posedge wb_clk_i);
            #1;
        end
        rdat = wbs_dat_o;
        // Cycle ends after the edge that closes the ack cycle
        @(posedge wb_clk_i);
        #2;
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_access(1'b1, adr, wdat, 4'hF, unused);
    endtask

    task automatic wb_read(input logic [31:0] adr, output logic [31:0] rdat);
        wb_access(1'b0, adr, 32'h0, 4'hF, rdat);
    endtask

    task automatic test_reset_state;
        check("io_out_o", io_out_o, 38'h0);
        check("io_oeb_o", io_oeb_o, {38{1'b1}});
        check("la_data_out_o", la_data_out_o, 128'h0);
        check("irq_o", irq_o, 3'b0);
    endtask

    task automatic test_sram;
        logic [7:0]  addrs [16];
        logic [31:0] rd;
        logic [31:0] wdat;
        logic [31:0] merged;
        for (int i = 0; i < 16; i++) begin
            addrs[i] = 8'($random(seed));
            wdat     = $random(seed);
            wb_write(SRAM_BASE | (32'(addrs[i]) << 2), wdat);
            sram_model[addrs[i]] = wdat;
        end
        for (int i = 0; i < 16; i++) begin
            wb_read(SRAM_BASE | (32'(addrs[i]) << 2), rd);
            check($sformatf("sram[%0h]", addrs[i]), rd, sram_model[addrs[i]]);
        end
        // Byte lanes 0 and 2 only
        wb_write(SRAM_BASE | 32'h100, 32'h1122_3344);
        wb_access(1'b1, SRAM_BASE | 32'h100, 32'hAABB_CCDD, 4'b0101, rd);
        merged = 32'h11BB_33DD;
        sram_model[8'h40] = merged;
        wb_read(SRAM_BASE | 32'h100, rd);
        check("sram[40] after sel 0101", rd, merged);
    endtask

    task automatic test_gpio_routing;
        logic [31:0] rd;
        wb_write(team_addr(2, 0), 32'h0000_005A);
        for (int p = 0; p < 8; p++)
            wb_write(GPIO_BASE + 32'(p * 4), 32'd2);
        check("io_out_o[7:0]", io_out_o[7:0], 8'h5A);
        check("io_oeb_o[7:0]", io_oeb_o[7:0], 8'h00);
        check("io_out_o[37:8]", io_out_o[37:8], 30'h0);          // Still unselected
        check("io_oeb_o[37:8]", io_oeb_o[37:8], {30{1'b1}});
        wb_read(GPIO_BASE + 32'd4, rd);
        check("gpio select 1", rd, 32'd2);
        // No team 3, pin 1 falls back to an idle input
        wb_write(GPIO_BASE + 32'd4, 32'd3);
        check("io_out_o[1]", io_out_o[1], 1'b0);
        check("io_oeb_o[1]", io_oeb_o[1], 1'b1);
        wb_read(GPIO_BASE + 32'd4, rd);
        check("gpio select 1", rd, 32'd3);
    endtask

    task automatic test_la_routing;
        logic [31:0] rd;
        logic [31:0] scratch;
        scratch = $random(seed);
        wb_write(team_addr(1, 0), scratch);
        wb_write(LA_BASE + 32'd8, 32'd1);    // Lane 2
        check("la_data_out_o[95:64]", la_data_out_o[95:64], scratch);
        check("la_data_out_o[63:0]", la_data_out_o[63:0], 64'h0);
        check("la_data_out_o[127:96]", la_data_out_o[127:96], 32'h0);
        wb_read(team_addr(1, 3), rd);
        check("team1 reg3", rd, io_in_i[31:0]);
    endtask

    task automatic test_team_copy;
        logic [31:0] rd;
        logic [31:0] scratch;
        int          polls;
        scratch = $random(seed);
        polls   = 0;
        wb_write(team_addr(1, 0), scratch);
        wb_write(team_addr(1, 2), 32'h21);
        wb_write(team_addr(1, 1), 32'h1);     // Start the copy
        wb_read(team_addr(1, 1), rd);
        while (rd[1] !== 1'b0) begin
            if (polls == 20) begin
                $display("Timeout: team 1 copy manager stayed busy");
                stop_with_failure();
            end
            polls++;
            wb_read(team_addr(1, 1), rd);
        end
        sram_model[8'h21] = scratch;
        wb_read(SRAM_BASE | 32'h84, rd);
        check("sram[21] after copy", rd, scratch);
    endtask

    task automatic test_unmapped;
        logic [31:0] rd;
        wb_read(32'h4000_0000, rd);
        check("unmapped read data", rd, 32'hDEAD_BEEF);
        wb_read(SRAM_BASE | 32'h84, rd);      // Bus still usable
        check("sram[21] after unmapped", rd, sram_model[8'h21]);
    endtask

    initial begin
        seed         = 32'h585c;
        wb_clk_i     = 1'b0;
        rst_i        = 1'b1;
        wbs_cyc_i    = 1'b0;
        wbs_stb_i    = 1'b0;
        wbs_we_i     = 1'b0;
        wbs_sel_i    = 4'h0;
        wbs_dat_i    = 32'h0;
        wbs_adr_i    = 32'h0;
        la_data_in_i = {$random(seed), $random(seed), $random(seed), $random(seed)};
        io_in_i      = 38'({$random(seed), $random(seed)});
        repeat (4) @(posedge wb_clk_i);
        #2;
        rst_i = 1'b0;

        test_reset_state();
        test_sram();
        test_gpio_routing();
        test_la_routing();
        test_team_copy();
        test_unmapped();

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: all.f
nebula_pkg.sv
wb_arbiter.sv
wb_decoder.sv
wb_sram.sv
gpio_mux.sv
la_mux.sv
team_sample.sv
nebula_top.sv
tb_nebula.sv

// File: run.sh
#!/bin/sh
# Build and run the fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module tb_nebula -o tb_nebula_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_nebula_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
